// ==== project.f ====
design/flash_pkg.sv
design/flash_cmd_seq.sv
design/spi_byte_shifter.sv
design/read_word_buffer.sv
design/spi_flash_reader.sv
verification/spi_flash_reader_assert.sv
verification/read_checker.sv
verification/tb_spi_flash_reader.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_spi_flash_reader
FILELIST  := project.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/tb_spi_flash_reader.sv ====
// testbench top for the SPI flash reader; runs the request table against a flash model
`default_nettype none

module tb_spi_flash_reader;

    localparam int ADDR_W   = flash_pkg::ADDR_W;
    localparam int WORD_W   = flash_pkg::WORD_W;
    localparam int N_REQ    = 24;
    localparam int LIMIT    = N_REQ * 700 + 200;
    localparam int IDLE_GAP = 200;

    logic              clk = 1'b0;
    logic              resetn;
    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;
    logic              req_ready;
    logic [WORD_W-1:0] rdata;
    logic [WORD_W-1:0] exp_word;
    logic              flash_csb;
    logic              flash_clk;
    logic              flash_io0;
    logic              flash_io1;

    logic [ADDR_W-1:0] addr_tab [N_REQ];
    logic [WORD_W-1:0] word_tab [N_REQ];
    int                gap_tab  [N_REQ];

    int data_errs;
    int frame_errs;
    int idle_errs;
    int done_count = 0;
    int cycles = 0;

    always #4 clk = ~clk;

    spi_flash_reader #(
        .ADDR_W (ADDR_W),
        .WORD_W (WORD_W)
    ) dut (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid_i (req_valid),
        .req_addr_i  (req_addr),
        .req_ready_o (req_ready),
        .rdata_o     (rdata),
        .flash_csb_o (flash_csb),
        .flash_clk_o (flash_clk),
        .flash_io0_o (flash_io0),
        .flash_io1_i (flash_io1)
    );

    read_checker #(
        .ADDR_W (ADDR_W),
        .WORD_W (WORD_W)
    ) chk (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_ready_i  (req_ready),
        .rdata_i      (rdata),
        .exp_word_i   (exp_word),
        .flash_csb_i  (flash_csb),
        .flash_clk_i  (flash_clk),
        .flash_io0_i  (flash_io0),
        .data_errs_o  (data_errs),
        .frame_errs_o (frame_errs),
        .idle_errs_o  (idle_errs)
    );

    bind spi_flash_reader spi_flash_reader_assert #(
        .ADDR_W (ADDR_W)
    ) u_assert (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_ready_o (req_ready_o),
        .flash_csb_o (flash_csb_o),
        .flash_clk_o (flash_clk_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // flash contents: low byte ^ middle byte ^ 5A
    function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        logic [WORD_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = mem_byte(a + ADDR_W'(i));   // lsb first
        end
        return w;
    endfunction

    task automatic build_table();
        logic [31:0]       seed;
        logic [ADDR_W-1:0] prev;
        logic [ADDR_W-1:0] cand;
        seed = 32'hba60;
        addr_tab[0]  = 24'h000100;
        addr_tab[1]  = 24'h000104;
        addr_tab[2]  = 24'h000108;
        addr_tab[3]  = 24'h00010c;
        addr_tab[4]  = 24'h000040;   // backward jump
        addr_tab[5]  = 24'h000044;
        addr_tab[6]  = 24'hfffff8;
        addr_tab[7]  = 24'hfffffc;
        addr_tab[8]  = 24'h000000;   // wraps
        addr_tab[9]  = 24'h000004;
        addr_tab[10] = 24'h000100;
        for (int i = 11; i < N_REQ; i++) begin
            prev = addr_tab[i-1];
            if (i % 3 == 0) begin
                addr_tab[i] = prev + ADDR_W'(4);
            end else begin
                do begin
                    seed = xorshift(seed);
                    cand = {seed[ADDR_W-1:2], 2'b00};
                end while (cand == prev || cand == prev + ADDR_W'(4) ||
                           cand == prev + ADDR_W'(8));
                addr_tab[i] = cand;
            end
        end
        for (int i = 0; i < N_REQ; i++) begin
            word_tab[i] = mem_word(addr_tab[i]);
            gap_tab[i]  = (i % 5 == 4) ? IDLE_GAP : 0;
        end
    endtask

    // flash model, single lane, mode 0
    logic [31:0]       in_shift = '0;
    logic [31:0]       in_bits = '0;
    logic [31:0]       data_bits = '0;
    logic              in_data = 1'b0;
    logic [ADDR_W-1:0] rd_addr = '0;
    logic [ADDR_W-1:0] out_addr;
    logic [7:0]        out_byte;
    logic [2:0]        bit_sel;

    always @(posedge flash_clk or posedge flash_csb) begin
        if (flash_csb) begin
            in_bits   = '0;
            data_bits = '0;
            in_data   = 1'b0;
        end else if (in_data) begin
            data_bits = data_bits + 32'd1;
        end else begin
            in_shift = {in_shift[30:0], flash_io0};
            in_bits  = in_bits + 32'd1;
            if (in_bits == 32'd32 && in_shift[31:24] == flash_pkg::CMD_READ) begin
                rd_addr = in_shift[23:0];
                in_data = 1'b1;
            end
        end
    end

    assign out_addr  = rd_addr + data_bits[ADDR_W+2:3];
    assign out_byte  = mem_byte(out_addr);
    assign bit_sel   = 3'd7 - data_bits[2:0];   // msb first
    assign flash_io1 = in_data ? out_byte[bit_sel] : 1'b0;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d requests served",
                     cycles, done_count, N_REQ);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int total;
        resetn    = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        exp_word  = '0;
        build_table();
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < N_REQ; i++) begin
            if (gap_tab[i] > 0) begin
                req_valid <= 1'b0;   // let the frame settle on a held prefetch
                repeat (gap_tab[i]) @(posedge clk);
            end
            req_valid <= 1'b1;
            req_addr  <= addr_tab[i];
            exp_word  <= word_tab[i];
            @(posedge clk);
            while (!req_ready) @(posedge clk);
            done_count++;
        end
        req_valid <= 1'b0;
        repeat (4) @(posedge clk);
        total = data_errs + frame_errs + idle_errs + dut.u_assert.fails;
        $display("errors: data %0d, frame %0d, idle %0d, assertion %0d; requests %0d of %0d",
                 data_errs, frame_errs, idle_errs, dut.u_assert.fails, done_count, N_REQ);
        if (total == 0 && done_count == N_REQ) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/read_checker.sv ====
// watches the request port and flash pins of the reader and counts mismatches
`default_nettype none

module read_checker #(
    parameter int ADDR_W = 24,
    parameter int WORD_W = 32
) (
    input  wire               clk,
    input  wire               resetn,
    input  wire               req_valid_i,
    input  wire [ADDR_W-1:0]  req_addr_i,
    input  wire               req_ready_i,
    input  wire [WORD_W-1:0]  rdata_i,
    input  wire [WORD_W-1:0]  exp_word_i,
    input  wire               flash_csb_i,
    input  wire               flash_clk_i,
    input  wire               flash_io0_i,
    output int                data_errs_o,
    output int                frame_errs_o,
    output int                idle_errs_o
);

    logic [31:0]       shift = '0;
    int                bits = 0;
    int                frames = 0;
    int                new_frames = 0;   // read frames since last handshake
    int                idle = 0;
    logic [ADDR_W-1:0] frame_addr = '0;
    logic [ADDR_W-1:0] prev_addr = '0;
    logic              seen = 1'b0;
    logic              seq;
    logic [7:0]        exp_cmd;

    initial begin
        data_errs_o  = 0;
        frame_errs_o = 0;
        idle_errs_o  = 0;
    end

    always @(posedge clk) begin
        if (resetn) begin
            if (flash_csb_i) begin
                bits = 0;
            end else if (flash_clk_i) begin   // io0 stable in the high phase
                shift = {shift[30:0], flash_io0_i};
                bits  = bits + 1;
                if (bits == 8) begin
                    exp_cmd = (frames == 0) ? flash_pkg::CMD_RESET_CONT :
                              (frames == 1) ? flash_pkg::CMD_WAKE : flash_pkg::CMD_READ;
                    if (shift[7:0] != exp_cmd) begin
                        frame_errs_o++;
                        $display("ERROR flash_io0_o command of frame %0d: got %h expected %h",
                                 frames, shift[7:0], exp_cmd);
                    end
                    frames = frames + 1;
                end
                if (bits == 32 && shift[31:24] == flash_pkg::CMD_READ) begin
                    frame_addr = shift[23:0];
                    new_frames = new_frames + 1;
                end
            end
            if (req_valid_i && req_ready_i) begin
                if (rdata_i !== exp_word_i) begin
                    data_errs_o++;
                    $display("ERROR rdata_o at address %h: got %h expected %h",
                             req_addr_i, rdata_i, exp_word_i);
                end
                seq = seen && (req_addr_i == prev_addr + ADDR_W'(4));
                if (seq && new_frames != 0) begin
                    frame_errs_o++;
                    $display("sequential request for %h opened a new read frame", req_addr_i);
                end
                if (!seq && new_frames != 1) begin
                    frame_errs_o++;
                    $display("request for %h opened %0d read frames instead of one",
                             req_addr_i, new_frames);
                end
                if (!seq && new_frames == 1 && frame_addr != req_addr_i) begin
                    frame_errs_o++;
                    $display("ERROR flash_io0_o frame address: got %h expected %h",
                             frame_addr, req_addr_i);
                end
                prev_addr  = req_addr_i;
                seen       = 1'b1;
                new_frames = 0;
                idle       = 0;
            end else if (seen && !req_valid_i) begin
                idle = idle + 1;
                if (idle > 150 && (flash_clk_i || flash_csb_i)) begin   // frame must be parked
                    idle_errs_o++;
                    $display("flash clock running or chip select high while prefetch is held");
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/spi_flash_reader_assert.sv ====
// concurrent checks on the request handshake and flash pins, bound into the reader top level
`default_nettype none

module spi_flash_reader_assert #(
    parameter int ADDR_W = 24
) (
    input wire              clk,
    input wire              resetn,
    input wire              req_valid_i,
    input wire [ADDR_W-1:0] req_addr_i,
    input wire              req_ready_o,
    input wire              flash_csb_o,
    input wire              flash_clk_o
);

    int fails = 0;

    req_hold: assert property (@(posedge clk) disable iff (!resetn)
        (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_addr_i)))
        else begin
            fails++;
            $error("request dropped or changed before req_ready_o");
        end

    // a buffered word only exists inside an open read frame
    ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        req_ready_o |-> (req_valid_i && !flash_csb_o))
        else begin
            fails++;
            $error("req_ready_o high without req_valid_i or with chip select high");
        end

    clk_idle_deselected: assert property (@(posedge clk) disable iff (!resetn)
        flash_csb_o |-> !flash_clk_o)
        else begin
            fails++;
            $error("flash_clk_o active while flash_csb_o is high");
        end

    reset_state: assert property (@(posedge clk)
        !resetn |=> (flash_csb_o && !req_ready_o))
        else begin
            fails++;
            $error("chip select low or req_ready_o high in reset");
        end

endmodule

`default_nettype wire

// ==== design/spi_flash_reader.sv ====
// top level of the read-only SPI flash reader; request port in, flash pins out
`default_nettype none

module spi_flash_reader #(
    parameter int ADDR_W = flash_pkg::ADDR_W,
    parameter int WORD_W = flash_pkg::WORD_W
) (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  req_valid_i,
    input  wire [ADDR_W-1:0]     req_addr_i,
    output logic                 req_ready_o,
    output logic [WORD_W-1:0]    rdata_o,
    output logic                 flash_csb_o,
    output logic                 flash_clk_o,
    output logic                 flash_io0_o,
    input  wire                  flash_io1_i
);

    logic             cmd_valid;
    logic             cmd_ready;
    flash_pkg::byte_t cmd_byte;
    flash_pkg::tag_t  cmd_tag;
    logic             xfer_restart;
    logic             rx_valid;
    flash_pkg::byte_t rx_byte;
    flash_pkg::tag_t  rx_tag;
    logic             jump;
    logic             prefetch_hold;

    flash_cmd_seq #(
        .ADDR_W (ADDR_W)
    ) u_seq (
        .clk             (clk),
        .resetn          (resetn),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .jump_i          (jump),
        .prefetch_hold_i (prefetch_hold),
        .rx_valid_i      (rx_valid),
        .cmd_valid_o     (cmd_valid),
        .cmd_byte_o      (cmd_byte),
        .cmd_tag_o       (cmd_tag),
        .cmd_ready_i     (cmd_ready),
        .xfer_restart_o  (xfer_restart)
    );

    spi_byte_shifter u_shifter (
        .clk         (clk),
        .resetn      (resetn),
        .restart_i   (xfer_restart),
        .cmd_valid_i (cmd_valid),
        .cmd_byte_i  (cmd_byte),
        .cmd_tag_i   (cmd_tag),
        .cmd_ready_o (cmd_ready),
        .rx_valid_o  (rx_valid),
        .rx_byte_o   (rx_byte),
        .rx_tag_o    (rx_tag),
        .flash_csb_o (flash_csb_o),
        .flash_clk_o (flash_clk_o),
        .flash_io0_o (flash_io0_o),
        .flash_io1_i (flash_io1_i)
    );

    read_word_buffer #(
        .ADDR_W (ADDR_W),
        .WORD_W (WORD_W)
    ) u_buffer (
        .clk             (clk),
        .resetn          (resetn),
        .restart_i       (xfer_restart),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .rx_valid_i      (rx_valid),
        .rx_byte_i       (rx_byte),
        .rx_tag_i        (rx_tag),
        .req_ready_o     (req_ready_o),
        .rdata_o         (rdata_o),
        .jump_o          (jump),
        .prefetch_hold_o (prefetch_hold)
    );

endmodule

`default_nettype wire

// ==== design/read_word_buffer.sv ====
// word buffer of the flash reader; packs rx bytes into words and answers the request port
`default_nettype none

module read_word_buffer #(
    parameter int ADDR_W = 24,
    parameter int WORD_W = 32
) (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  restart_i,
    input  wire                  req_valid_i,
    input  wire [ADDR_W-1:0]     req_addr_i,
    input  wire                  rx_valid_i,
    input  flash_pkg::byte_t     rx_byte_i,
    input  flash_pkg::tag_t      rx_tag_i,
    output logic                 req_ready_o,
    output logic [WORD_W-1:0]    rdata_o,
    output logic                 jump_o,
    output logic                 prefetch_hold_o
);

    logic [WORD_W-9:0] low_bytes;   // bytes 0..2 of word in progress
    logic [ADDR_W-1:0] word_addr;
    logic [ADDR_W-1:0] next_addr;
    logic              word_valid;
    logic              inc_q;       // next word is a prefetch
    logic              hit;
    logic              word_done;

    assign next_addr = word_addr + ADDR_W'(flash_pkg::WORD_BYTES);
    assign word_done = rx_valid_i && (rx_tag_i == flash_pkg::tag_t'(flash_pkg::WORD_BYTES));

    assign hit         = req_valid_i && word_valid && (req_addr_i == word_addr);
    assign req_ready_o = hit;

    // anything but the current or next word needs a new frame
    assign jump_o = req_valid_i && !hit && (req_addr_i != next_addr) && word_valid;

    always_ff @(posedge clk) begin
        if (!resetn || restart_i) begin
            word_valid      <= 1'b0;
            inc_q           <= 1'b0;
            prefetch_hold_o <= 1'b0;
        end else begin
            if (word_done) begin
                word_valid      <= 1'b1;
                inc_q           <= 1'b1;
                prefetch_hold_o <= inc_q;   // only prefetched words hold the frame
            end
            if (req_valid_i) prefetch_hold_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < flash_pkg::WORD_BYTES; i++) begin
            if (rx_valid_i && rx_tag_i == flash_pkg::tag_t'(i)) begin
                low_bytes[8*(i-1) +: 8] <= rx_byte_i;
            end
        end
        if (word_done) begin
            rdata_o   <= {rx_byte_i, low_bytes};   // lsb first
            word_addr <= inc_q ? next_addr : req_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_byte_shifter.sv ====
// single-lane SPI byte engine; shifts one tagged byte per handshake and returns the rx byte
`default_nettype none

module spi_byte_shifter (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  restart_i,
    input  wire                  cmd_valid_i,
    input  flash_pkg::byte_t     cmd_byte_i,
    input  flash_pkg::tag_t      cmd_tag_i,
    output logic                 cmd_ready_o,
    output logic                 rx_valid_o,
    output flash_pkg::byte_t     rx_byte_o,
    output flash_pkg::tag_t      rx_tag_o,
    output logic                 flash_csb_o,
    output logic                 flash_clk_o,
    output logic                 flash_io0_o,
    input  wire                  flash_io1_i
);

    flash_pkg::byte_t obuf;
    flash_pkg::byte_t ibuf;
    flash_pkg::tag_t  tag_q;   // tag of byte in flight
    logic [3:0]       count;   // bits left

    logic busy;
    logic last_half;

    assign busy      = (count != 4'd0);
    assign last_half = (count == 4'd1) && flash_clk_o;   // final falling edge

    // next byte may start on the last falling edge
    assign cmd_ready_o = cmd_valid_i && !restart_i && (!busy || last_half);

    assign flash_io0_o = obuf[7];
    assign rx_byte_o   = ibuf;

    always_ff @(posedge clk) begin
        if (!resetn || restart_i) begin
            flash_csb_o <= 1'b1;
            flash_clk_o <= 1'b0;
            count       <= 4'd0;
            rx_valid_o  <= 1'b0;
        end else begin
            rx_valid_o <= last_half;
            if (busy) begin
                flash_clk_o <= !flash_clk_o;
                if (flash_clk_o) count <= count - 4'd1;
            end
            if (cmd_ready_o) begin
                flash_csb_o <= 1'b0;   // held low until restart
                flash_clk_o <= 1'b0;
                count       <= 4'd8;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            if (flash_clk_o) begin
                obuf <= {obuf[6:0], 1'b0};          // io0 moves on falling edge
            end else begin
                ibuf <= {ibuf[6:0], flash_io1_i};   // io1 sampled on rising edge
            end
        end
        if (last_half) rx_tag_o <= tag_q;
        if (cmd_ready_o) begin
            obuf  <= cmd_byte_i;
            tag_q <= cmd_tag_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/flash_cmd_seq.sv ====
// command FSM of the flash reader; wakes the flash, opens read frames and issues data slots
`default_nettype none

module flash_cmd_seq #(
    parameter int ADDR_W = 24
) (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  req_valid_i,
    input  wire [ADDR_W-1:0]     req_addr_i,
    input  wire                  jump_i,
    input  wire                  prefetch_hold_i,
    input  wire                  rx_valid_i,
    output logic                 cmd_valid_o,
    output flash_pkg::byte_t     cmd_byte_o,
    output flash_pkg::tag_t      cmd_tag_o,
    input  wire                  cmd_ready_i,
    output logic                 xfer_restart_o
);

    typedef enum logic [3:0] {
        S_BOOT,
        S_FF,
        S_FF_WAIT,
        S_AB,
        S_AB_WAIT,
        S_READ,
        S_ADDR2,
        S_ADDR1,
        S_ADDR0,
        S_D1,
        S_D2,
        S_D3,
        S_D4
    } state_t;

    state_t state;
    logic   restart_q;

    // a jump aborts the frame in the same cycle
    assign xfer_restart_o = restart_q || jump_i;

    always_comb begin
        cmd_valid_o = 1'b1;
        cmd_byte_o  = 8'h00;   // don't-care on io0 during data slots
        cmd_tag_o   = 3'd0;
        case (state)
            S_BOOT:    cmd_valid_o = 1'b0;
            S_FF:      cmd_byte_o  = flash_pkg::CMD_RESET_CONT;
            S_FF_WAIT: cmd_valid_o = 1'b0;
            S_AB:      cmd_byte_o  = flash_pkg::CMD_WAKE;
            S_AB_WAIT: cmd_valid_o = 1'b0;
            S_READ:    cmd_byte_o  = flash_pkg::CMD_READ;
            S_ADDR2: begin
                cmd_valid_o = req_valid_i;   // buffer is empty here, so any request misses
                cmd_byte_o  = req_addr_i[ADDR_W-1 -: 8];
            end
            S_ADDR1:   cmd_byte_o  = req_addr_i[15:8];
            S_ADDR0:   cmd_byte_o  = req_addr_i[7:0];
            S_D1:      cmd_tag_o   = 3'd1;
            S_D2:      cmd_tag_o   = 3'd2;
            S_D3:      cmd_tag_o   = 3'd3;
            S_D4: begin
                cmd_valid_o = !prefetch_hold_i || req_valid_i;   // stall the frame
                cmd_tag_o   = 3'd4;
            end
            default:   cmd_valid_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= S_BOOT;
            restart_q <= 1'b0;
        end else begin
            restart_q <= 1'b0;
            case (state)
                S_BOOT: state <= S_FF;
                S_FF: begin
                    if (cmd_ready_i) state <= S_FF_WAIT;
                end
                S_FF_WAIT: begin
                    if (rx_valid_i) begin   // end of first wake frame
                        restart_q <= 1'b1;
                        state     <= S_AB;
                    end
                end
                S_AB: begin
                    if (cmd_ready_i) state <= S_AB_WAIT;
                end
                S_AB_WAIT: begin
                    if (rx_valid_i) begin
                        restart_q <= 1'b1;
                        state     <= S_READ;
                    end
                end
                S_READ: begin
                    if (cmd_ready_i) state <= S_ADDR2;
                end
                S_ADDR2: begin
                    if (cmd_ready_i) state <= S_ADDR1;
                end
                S_ADDR1: begin
                    if (cmd_ready_i) state <= S_ADDR0;
                end
                S_ADDR0: begin
                    if (cmd_ready_i) state <= S_D1;
                end
                S_D1: begin
                    if (cmd_ready_i) state <= S_D2;
                end
                S_D2: begin
                    if (cmd_ready_i) state <= S_D3;
                end
                S_D3: begin
                    if (cmd_ready_i) state <= S_D4;
                end
                S_D4: begin
                    if (cmd_ready_i) state <= S_D1;
                end
                default: state <= S_BOOT;
            endcase
            if (jump_i) begin
                state <= S_READ;   // new frame at the requested address
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/flash_pkg.sv ====
// shared widths, byte and tag types and command codes for the SPI flash reader
`default_nettype none

package flash_pkg;

    localparam int ADDR_W     = 24;   // flash byte address
    localparam int WORD_W     = 32;   // word handed to the requester
    localparam int WORD_BYTES = 4;

    typedef logic [7:0] byte_t;

    // 0 = command or address byte, rx data dropped
    // 1..4 = byte 0..3 of a data word
    typedef logic [2:0] tag_t;

    localparam byte_t CMD_RESET_CONT = 8'hFF;   // leaves continuous-read mode
    localparam byte_t CMD_WAKE       = 8'hAB;   // release from power-down
    localparam byte_t CMD_READ       = 8'h03;   // single-lane read

endpackage

`default_nettype wire
